//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bigfifo
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bigfifo_params.svh
`ifndef BIGFIFO_PARAMS_SVH
`define BIGFIFO_PARAMS_SVH

////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////

// one input sample from the source
`define BF_SAMPLE_W 16
// one stored word, two samples packed low first
`define BF_WORD_W 32

////////////////////////////////////////////////////////////
// depths, all in 32-bit words
////////////////////////////////////////////////////////////

// input mini-FIFO in front of the bulk store
`define BF_IN_DEPTH 16
// bulk circular store, stands in for the external memory
`define BF_BULK_DEPTH 256
// output mini-FIFO in front of the host reader
`define BF_OUT_DEPTH 32
// words moved per burst; depths above are multiples of it
`define BF_BURST_LEN 4

// every occupancy count is in 16-bit words
`define BF_COUNT_W 16

`endif

//--- bigfifo_pkg.sv
`default_nettype none

`include "bigfifo_params.svh"

package bigfifo_pkg;

	////////////////////////////////////////////////////////////
	// payload and count types
	////////////////////////////////////////////////////////////

	// one stored word, high sample in the upper half
	typedef logic [`BF_WORD_W-1:0] word_t;

	// occupancy in 16-bit words
	typedef logic [`BF_COUNT_W-1:0] count_t;

	// one word handed from a stage to the next
	typedef struct packed {
		logic  valid;
		word_t data;
	} xfer_t;

	// what a stage reports of its own fill
	// empty means no whole 32-bit word is held
	typedef struct packed {
		count_t count;
		logic   empty;
	} level_t;

	////////////////////////////////////////////////////////////
	// burst mover states
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		MV_IDLE,
		MV_FILL,
		MV_DRAIN
	} mover_state_e;

endpackage

`default_nettype wire

//--- bigfifo_stimulus.txt
# test  op  arg   R reset, W write samples, P read words, B block size,
# A wait for out_words (16-bit words) then check, I check in_words
1 R 0
1 A 0
2 W 32
2 A 32
2 I 0
2 P 16
2 A 0
3 W 128
3 A 64
3 P 20
3 A 64
3 P 44
3 A 0
4 W 9
4 A 8
4 I 1
4 W 7
4 A 16
4 I 0
4 P 8
4 A 0
5 W 48
5 A 48
5 B 10
5 B 24
5 B 25
5 B 0
5 P 24
5 A 0
5 B 1
6 W 8
6 A 8
6 P 4
6 P 3
6 A 0
6 R 0
6 P 1

//--- bigfifo_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "bigfifo_params.svh"

module bigfifo_top (
	input  wire logic                    ti_clk,
	input  wire logic                    rst_n,
	input  wire logic                    wr_en,
	input  wire logic [`BF_SAMPLE_W-1:0] wr_sample,
	input  wire logic                    rd_en,
	input  bigfifo_pkg::count_t          block_size,
	output bigfifo_pkg::word_t           rd_data,
	output logic                         block_ready,
	output bigfifo_pkg::count_t          in_words,
	output bigfifo_pkg::count_t          bulk_words,
	output bigfifo_pkg::count_t          out_words,
	output bigfifo_pkg::count_t          total_words
);

	// stage to stage hand-off
	bigfifo_pkg::word_t  in_head;
	bigfifo_pkg::level_t in_level;
	bigfifo_pkg::level_t out_level;
	bigfifo_pkg::xfer_t  out_push;
	logic                in_pop;

	////////////////////////////////////////////////////////////
	// the three stages
	////////////////////////////////////////////////////////////

	// pairs samples into words
	sample_packer u_packer (
		.ti_clk    (ti_clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_sample (wr_sample),
		.in_pop    (in_pop),
		.in_head   (in_head),
		.in_level  (in_level)
	);

	// bulk store with burst moves both ways
	burst_mover u_mover (
		.ti_clk     (ti_clk),
		.rst_n      (rst_n),
		.in_head    (in_head),
		.in_level   (in_level),
		.out_level  (out_level),
		.in_pop     (in_pop),
		.out_push   (out_push),
		.bulk_words (bulk_words)
	);

	// host read side
	out_fifo u_out (
		.ti_clk      (ti_clk),
		.rst_n       (rst_n),
		.out_push    (out_push),
		.rd_en       (rd_en),
		.block_size  (block_size),
		.rd_data     (rd_data),
		.out_level   (out_level),
		.block_ready (block_ready)
	);

	assign in_words  = in_level.count;
	assign out_words = out_level.count;

	// whole-FIFO fill in 16-bit words, one cycle behind the stages
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			total_words <= '0;
		end else begin
			total_words <= in_words + bulk_words + out_words;
		end
	end

endmodule

`default_nettype wire

//--- burst_mover.sv
`timescale 1ns/100ps
`default_nettype none

`include "bigfifo_params.svh"

module burst_mover (
	input  wire logic            ti_clk,
	input  wire logic            rst_n,
	input  bigfifo_pkg::word_t   in_head,
	input  bigfifo_pkg::level_t  in_level,
	input  bigfifo_pkg::level_t  out_level,
	output logic                 in_pop,
	output bigfifo_pkg::xfer_t   out_push,
	output bigfifo_pkg::count_t  bulk_words
);

	localparam int PTR_W  = $clog2(`BF_BULK_DEPTH);
	localparam int CNT_W  = $clog2(`BF_BULK_DEPTH + 1);
	localparam int BEAT_W = $clog2(`BF_BURST_LEN);

	// burst size and output depth in 16-bit units
	localparam bigfifo_pkg::count_t BURST_HALVES = bigfifo_pkg::count_t'(2 * `BF_BURST_LEN);
	localparam bigfifo_pkg::count_t OUT_HALVES   = bigfifo_pkg::count_t'(2 * `BF_OUT_DEPTH);

	// bulk circular store
	bigfifo_pkg::word_t bulk_mem [`BF_BULK_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   bulk_cnt;

	bigfifo_pkg::mover_state_e state;
	bigfifo_pkg::mover_state_e state_nxt;
	logic [BEAT_W-1:0]         beat;
	logic                      last_beat;

	logic               fill_ok;
	logic               drain_ok;
	logic               do_fill;
	logic               do_drain;
	logic               rd_valid_q;
	bigfifo_pkg::word_t rd_data_q;

	////////////////////////////////////////////////////////////
	// burst start rules
	////////////////////////////////////////////////////////////

	// a whole burst waits in the input and fits in the store
	assign fill_ok = !in_level.empty
		&& (in_level.count >= BURST_HALVES)
		&& (bulk_cnt <= CNT_W'(`BF_BULK_DEPTH - `BF_BURST_LEN));

	// a whole burst in the store and room in the output
	// the push still in flight from the last drain is counted too
	assign drain_ok = (bulk_cnt >= CNT_W'(`BF_BURST_LEN))
		&& (out_level.count + bigfifo_pkg::count_t'({out_push.valid, 1'b0})
			+ BURST_HALVES <= OUT_HALVES);

	assign last_beat = (beat == BEAT_W'(`BF_BURST_LEN - 1));
	assign do_fill   = (state == bigfifo_pkg::MV_FILL);
	assign do_drain  = (state == bigfifo_pkg::MV_DRAIN);

	// drain wins so the host side never starves behind a busy input
	always_comb begin
		state_nxt = state;
		case (state)
			bigfifo_pkg::MV_IDLE: begin
				if (drain_ok) begin
					state_nxt = bigfifo_pkg::MV_DRAIN;
				end else if (fill_ok) begin
					state_nxt = bigfifo_pkg::MV_FILL;
				end
			end
			bigfifo_pkg::MV_FILL, bigfifo_pkg::MV_DRAIN: begin
				if (last_beat) begin
					state_nxt = bigfifo_pkg::MV_IDLE;
				end
			end
			default: begin
				state_nxt = bigfifo_pkg::MV_IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// state, beats, pointers and word count
	////////////////////////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			state      <= bigfifo_pkg::MV_IDLE;
			beat       <= '0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			bulk_cnt   <= '0;
			rd_valid_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == bigfifo_pkg::MV_IDLE || last_beat) begin
				beat <= '0;
			end else begin
				beat <= beat + 1'b1;
			end
			// pointers wrap on their own, depth is a power of two
			if (do_fill) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_drain) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// a word leaves the count at its read, not at its push
			bulk_cnt   <= bulk_cnt + CNT_W'(do_fill) - CNT_W'(do_drain);
			rd_valid_q <= do_drain;
		end
	end

	// store write and one-cycle read
	always_ff @(posedge ti_clk) begin
		if (do_fill) begin
			bulk_mem[wr_ptr] <= in_head;
		end
		if (do_drain) begin
			rd_data_q <= bulk_mem[rd_ptr];
		end
	end

	// one word per fill beat leaves the input
	assign in_pop = do_fill;

	// push trails its read by one cycle
	assign out_push.valid = rd_valid_q;
	assign out_push.data  = rd_data_q;

	assign bulk_words = bigfifo_pkg::count_t'({bulk_cnt, 1'b0});

	a_bulk_bound: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		bulk_cnt <= CNT_W'(`BF_BULK_DEPTH)
	);

	// first drain beat, the output must still hold room for the whole burst
	a_drain_room: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		(do_drain && beat == '0) |-> (out_level.count + BURST_HALVES <= OUT_HALVES)
	);

endmodule

`default_nettype wire

//--- out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "bigfifo_params.svh"

module out_fifo (
	input  wire logic            ti_clk,
	input  wire logic            rst_n,
	input  bigfifo_pkg::xfer_t   out_push,
	input  wire logic            rd_en,
	input  bigfifo_pkg::count_t  block_size,
	output bigfifo_pkg::word_t   rd_data,
	output bigfifo_pkg::level_t  out_level,
	output logic                 block_ready
);

	localparam int PTR_W = $clog2(`BF_OUT_DEPTH);
	localparam int CNT_W = $clog2(`BF_OUT_DEPTH + 1);

	// output mini-FIFO storage
	bigfifo_pkg::word_t mem [`BF_OUT_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   word_cnt;

	logic pop;

	// a read of an empty FIFO is dropped and rd_data holds
	assign pop = rd_en && (word_cnt != '0);

	////////////////////////////////////////////////////////////
	// pointers, count, read port and block flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			word_cnt    <= '0;
			rd_data     <= '0;
			block_ready <= 1'b0;
		end else begin
			if (out_push.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr  <= rd_ptr + 1'b1;
				// registered read, visible from the next cycle
				rd_data <= mem[rd_ptr];
			end
			word_cnt <= word_cnt + CNT_W'(out_push.valid) - CNT_W'(pop);
			// block_size is in 32-bit words, same unit as word_cnt
			block_ready <= (bigfifo_pkg::count_t'(word_cnt) >= block_size);
		end
	end

	// payload write
	always_ff @(posedge ti_clk) begin
		if (out_push.valid) begin
			mem[wr_ptr] <= out_push.data;
		end
	end

	// reported in 16-bit words
	assign out_level.count = bigfifo_pkg::count_t'({word_cnt, 1'b0});
	assign out_level.empty = (word_cnt == '0);

	// mover only drains with room for its whole burst
	a_no_push_full: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		out_push.valid |-> (word_cnt < CNT_W'(`BF_OUT_DEPTH))
	);

endmodule

`default_nettype wire

//--- sample_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "bigfifo_params.svh"

module sample_packer (
	input  wire logic                    ti_clk,
	input  wire logic                    rst_n,
	input  wire logic                    wr_en,
	input  wire logic [`BF_SAMPLE_W-1:0] wr_sample,
	input  wire logic                    in_pop,
	output bigfifo_pkg::word_t           in_head,
	output bigfifo_pkg::level_t          in_level
);

	localparam int PTR_W = $clog2(`BF_IN_DEPTH);
	localparam int CNT_W = $clog2(`BF_IN_DEPTH + 1);

	// pending low sample waiting for its partner
	logic                    pend_valid;
	logic [`BF_SAMPLE_W-1:0] pend_low;

	// input mini-FIFO storage and pointers
	bigfifo_pkg::word_t mem [`BF_IN_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   word_cnt;

	logic full;
	logic take_low;
	logic push;

	assign full = (word_cnt == CNT_W'(`BF_IN_DEPTH));

	// a lone low sample is only taken when a pair can still land
	// full cannot rise while a half is pending, since only this stage pushes
	assign take_low = wr_en && !pend_valid && !full;
	// second sample completes the pair and writes on the same edge
	assign push = wr_en && pend_valid;

	////////////////////////////////////////////////////////////
	// pairing and pointer control
	////////////////////////////////////////////////////////////
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			pend_valid <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			word_cnt   <= '0;
		end else begin
			if (take_low) begin
				pend_valid <= 1'b1;
			end else if (push) begin
				pend_valid <= 1'b0;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (in_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// net change of one, zero or minus one word
			word_cnt <= word_cnt + CNT_W'(push) - CNT_W'(in_pop);
		end
	end

	// sample payload and mini-FIFO storage
	always_ff @(posedge ti_clk) begin
		if (take_low) begin
			pend_low <= wr_sample;
		end
		if (push) begin
			// low sample sits in the lower half
			mem[wr_ptr] <= {wr_sample, pend_low};
		end
	end

	// show-ahead head for the mover
	assign in_head = mem[rd_ptr];

	// twice the stored words plus the pending half
	assign in_level.count = bigfifo_pkg::count_t'({word_cnt, 1'b0})
		+ bigfifo_pkg::count_t'(pend_valid);
	assign in_level.empty = (word_cnt == '0);

	// mover must only pop words that are really here
	a_no_pop_empty: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		in_pop |-> (word_cnt != '0)
	);

endmodule

`default_nettype wire

//--- tb_bigfifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "bigfifo_params.svh"

module tb_bigfifo;

	localparam int HALF_PERIOD = 50;
	// upper bound in cycles for one command
	localparam int CMD_CYCLES = 1000;
	// limit for one wait on out_words plus its quiet window
	localparam int WAIT_CYCLES = 600;
	// counts unchanged this long means no transfer is left
	localparam int QUIET_CYCLES = 4;
	localparam logic [31:0] LFSR_MASK = 32'h80200003;

	logic                    ti_clk;
	logic                    rst_n;
	logic                    wr_en;
	logic [`BF_SAMPLE_W-1:0] wr_sample;
	logic                    rd_en;
	bigfifo_pkg::count_t     block_size;
	bigfifo_pkg::word_t      rd_data;
	logic                    block_ready;
	bigfifo_pkg::count_t     in_words;
	bigfifo_pkg::count_t     bulk_words;
	bigfifo_pkg::count_t     out_words;
	bigfifo_pkg::count_t     total_words;

	// command table from the stimulus file
	int         cmd_test [$];
	logic [7:0] cmd_op [$];
	int         cmd_arg [$];
	logic       loaded;

	// reference model of whole words in write order
	bigfifo_pkg::word_t      exp_q [$];
	logic                    pend_valid;
	logic [`BF_SAMPLE_W-1:0] pend_sample;
	int                      model_halves;
	bigfifo_pkg::word_t      last_word;
	logic [31:0]             lfsr;
	// output halves at the last settled wait
	int                      settled_out;

	int cur_test;
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	int tests_done;

	bigfifo_top u_dut (
		.ti_clk      (ti_clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_sample   (wr_sample),
		.rd_en       (rd_en),
		.block_size  (block_size),
		.rd_data     (rd_data),
		.block_ready (block_ready),
		.in_words    (in_words),
		.bulk_words  (bulk_words),
		.out_words   (out_words),
		.total_words (total_words)
	);

	initial begin
		ti_clk = 1'b0;
		forever #HALF_PERIOD ti_clk = ~ti_clk;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois form shifting right and folding the taps in on a one
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ LFSR_MASK;
		end
		return n;
	endfunction

	// one lfsr step per sample bit
	task automatic next_sample(output logic [`BF_SAMPLE_W-1:0] s);
		s = '0;
		for (int b = 0; b < `BF_SAMPLE_W; b++) begin
			s = {s[`BF_SAMPLE_W-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// inputs change a little after the edge
	task automatic next_cycle();
		@(posedge ti_clk);
		#5;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		test_checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("** Error at %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d finished: %0d checks, %0d errors", t, test_checks, test_errors);
		tests_done++;
		test_checks = 0;
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// operations
	////////////////////////////////////////////////////////////
	task automatic apply_reset();
		rst_n = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
		exp_q.delete();
		pend_valid   = 1'b0;
		model_halves = 0;
		last_word    = '0;
		settled_out  = 0;
		// block_ready still holds its reset value here
		compare("block_ready", 32'(1'b0), 32'(block_ready));
		compare("in_words", 32'd0, 32'(in_words));
		compare("bulk_words", 32'd0, 32'(bulk_words));
		compare("out_words", 32'd0, 32'(out_words));
		compare("total_words", 32'd0, 32'(total_words));
		compare("rd_data", 32'd0, 32'(rd_data));
	endtask

	task automatic write_samples(input int n);
		logic [`BF_SAMPLE_W-1:0] s;
		for (int i = 0; i < n; i++) begin
			next_sample(s);
			wr_en     = 1'b1;
			wr_sample = s;
			// second of a pair completes a word with the low sample first
			if (pend_valid) begin
				exp_q.push_back({s, pend_sample});
				pend_valid = 1'b0;
			end else begin
				pend_sample = s;
				pend_valid  = 1'b1;
			end
			model_halves++;
			next_cycle();
		end
		wr_en = 1'b0;
	endtask

	// back to back reads where an empty output repeats the last word
	task automatic read_words(input int n);
		bigfifo_pkg::word_t exp;
		for (int i = 0; i < n; i++) begin
			if (out_words != '0 && exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				model_halves -= 2;
			end else begin
				exp = last_word;
			end
			rd_en = 1'b1;
			next_cycle();
			compare("rd_data", exp, rd_data);
			last_word = exp;
		end
		rd_en = 1'b0;
	endtask

	task automatic wait_out_words(input int target);
		int                  cycles;
		int                  quiet;
		int                  exp_in;
		int                  exp_bulk;
		bigfifo_pkg::count_t p_in;
		bigfifo_pkg::count_t p_bulk;
		bigfifo_pkg::count_t p_out;
		cycles = 0;
		quiet  = 0;
		while (out_words != 16'(target) && cycles < WAIT_CYCLES) begin
			next_cycle();
			cycles++;
		end
		// then wait until fills and drains have stopped
		while (quiet < QUIET_CYCLES && cycles < WAIT_CYCLES) begin
			p_in   = in_words;
			p_bulk = bulk_words;
			p_out  = out_words;
			next_cycle();
			cycles++;
			if (p_in == in_words && p_bulk == bulk_words && p_out == out_words) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
		if (cycles >= WAIT_CYCLES) begin
			checks++;
			test_checks++;
			errors++;
			test_errors++;
			$display("test %0d: the FIFO did not settle at %0d output words within %0d cycles",
				cur_test, target, WAIT_CYCLES);
		end
		settled_out = target;
		// whole bursts move on to the store and a smaller remainder stays in the input
		exp_in   = (model_halves - target) % (2 * `BF_BURST_LEN);
		exp_bulk = model_halves - target - exp_in;
		compare("out_words", 32'(target), 32'(out_words));
		compare("in_words", 32'(exp_in), 32'(in_words));
		compare("bulk_words", 32'(exp_bulk), 32'(bulk_words));
		compare("total_words", 32'(model_halves), 32'(total_words));
		// target counts halves and block_size whole words
		compare("block_ready", 32'((target / 2) >= block_size), 32'(block_ready));
	endtask

	task automatic set_block_size(input int n);
		block_size = 16'(n);
		next_cycle();
		compare("block_ready", 32'((settled_out / 2) >= n), 32'(block_ready));
	endtask

	task automatic load_commands(output logic ok);
		int         fd;
		int         n;
		int         t;
		int         a;
		logic [7:0] op;
		string      line;
		ok = 1'b0;
		fd = $fopen("bigfifo_stimulus.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// lines starting with a hash are notes
				if (n > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %c %d", t, op, a) == 3) begin
						cmd_test.push_back(t);
						cmd_op.push_back(op);
						cmd_arg.push_back(a);
					end
				end
			end
			$fclose(fd);
			ok = (cmd_test.size() > 0);
		end
	endtask

	////////////////////////////////////////////////////////////
	// watchdog scaled by the number of commands
	////////////////////////////////////////////////////////////
	initial begin
		wait (loaded);
		repeat (cmd_test.size() * CMD_CYCLES) @(posedge ti_clk);
		$display("watchdog expired after %0d cycles, the run is stopped",
			cmd_test.size() * CMD_CYCLES);
		$display("sim failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// command sequencer
	////////////////////////////////////////////////////////////
	initial begin
		logic ok;
		rst_n        = 1'b0;
		wr_en        = 1'b0;
		wr_sample    = '0;
		rd_en        = 1'b0;
		block_size   = 16'd1;
		loaded       = 1'b0;
		lfsr         = 32'd85394;
		pend_valid   = 1'b0;
		pend_sample  = '0;
		model_halves = 0;
		last_word    = '0;
		settled_out  = 0;
		cur_test     = -1;
		checks       = 0;
		errors       = 0;
		test_checks  = 0;
		test_errors  = 0;
		tests_done   = 0;
		load_commands(ok);
		if (!ok) begin
			$display("could not read any command from bigfifo_stimulus.txt");
			$display("sim failed");
			$finish;
		end else begin
			loaded = 1'b1;
			foreach (cmd_test[i]) begin
				// a new test number closes the previous test
				if (cmd_test[i] != cur_test) begin
					if (cur_test >= 0) begin
						report_test(cur_test);
					end
					cur_test = cmd_test[i];
				end
				case (cmd_op[i])
					"R": apply_reset();
					"W": write_samples(cmd_arg[i]);
					"P": read_words(cmd_arg[i]);
					"B": set_block_size(cmd_arg[i]);
					"A": wait_out_words(cmd_arg[i]);
					"I": compare("in_words", 32'(cmd_arg[i]), 32'(in_words));
					default: begin
						errors++;
						$display("unknown operation %c in command %0d", cmd_op[i], i);
					end
				endcase
			end
			report_test(cur_test);
			$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
			if (errors == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
bigfifo_pkg.sv
sample_packer.sv
burst_mover.sv
out_fifo.sv
bigfifo_top.sv
tb_bigfifo.sv
